//--- design/rp_bus_pkg.sv
// Bus map for a 32-bit word-only bus, with three mapped regions picked by address bits 22:20
package rp_bus_pkg;

  // Bus widths
  localparam int unsigned SYS_AW = 32;
  localparam int unsigned SYS_DW = 32;

  // Region numbers
  localparam logic [2:0] REG_HK     = 3'd0;  // Housekeeping
  localparam logic [2:0] REG_DACLVL = 3'd2;  // DAC levels, replaces the generators
  localparam logic [2:0] REG_CALIB  = 3'd5;  // ADC and DAC calibration

  // Housekeeping offsets
  localparam logic [19:0] HK_ID   = 20'h0;  // Read only
  localparam logic [19:0] HK_LOOP = 20'h4;  // Bit 0 is the digital loop
  localparam logic [19:0] HK_LED  = 20'h8;  // Bits 7:0

  // Calibration offsets, channel B one word above channel A
  localparam logic [19:0] CAL_ADC_MUL = 20'h00;
  localparam logic [19:0] CAL_ADC_SUM = 20'h08;
  localparam logic [19:0] CAL_DAC_MUL = 20'h10;
  localparam logic [19:0] CAL_DAC_SUM = 20'h18;

  // DAC level offsets
  localparam logic [19:0] LVL_A = 20'h0;
  localparam logic [19:0] LVL_B = 20'h4;

  localparam logic [19:0] CH_STRIDE = LVL_B - LVL_A;  // Step between channel words

  localparam logic [SYS_DW-1:0] HK_ID_VALUE = 32'h5270_0a01;

  // Same address word seen flat or split into fields
  typedef union packed {
    logic [SYS_AW-1:0] word;
    struct packed {
      logic [8:0]  unused;  // Bits 31:23
      logic [2:0]  region;  // Bits 22:20
      logic [19:0] offset;
    } fld;
  } rp_sys_addr_t;

endpackage

//--- design/rp_analog_pkg.sv
// Sample format is 14-bit two's complement, two channels, gains are Q2.14 so 0x4000 is unity
package rp_analog_pkg;

  localparam int unsigned DWS = 14;  // Sample width
  localparam int unsigned DWM = 16;  // Gain width
  localparam int unsigned CHN = 2;   // Channel count

  // Product is shifted down by this much
  localparam int unsigned GAIN_SHIFT = 14;

  // Gain after reset
  localparam logic signed [DWM-1:0] GAIN_UNITY = 16'sh4000;

  // Saturation limits of a 14-bit signed sample
  localparam logic signed [DWS-1:0] SAMPLE_MAX = 14'sh1fff;
  localparam logic signed [DWS-1:0] SAMPLE_MIN = -14'sh2000;

endpackage

//--- design/rp_linear.sv
// Two-cycle latency for data, gain and offset alike, result saturates to 14-bit signed
module rp_linear
  import rp_analog_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  logic signed [DWS-1:0] dat_i,  // Sample in
  input  logic signed [DWM-1:0] mul_i,  // Gain, Q2.14
  input  logic signed [DWS-1:0] sum_i,  // Offset
  output logic signed [DWS-1:0] dat_o
);

  logic signed [DWS+DWM-1:0] prod_q;  // Full product
  logic signed [DWS-1:0]     sum_q;   // Offset kept in step with the product
  logic signed [DWS+DWM-1:0] add_w;

  // Stage one
  always_ff @(posedge adc_clk or posedge top_rst)
  begin
    if (top_rst)
    begin
      prod_q <= '0;
      sum_q  <= '0;
    end
    else
    begin
      prod_q <= dat_i * mul_i;
      sum_q  <= sum_i;
    end
  end

  // Scale back and add offset, wide enough not to wrap
  assign add_w = (prod_q >>> GAIN_SHIFT) + sum_q;

  // Stage two with clamp
  always_ff @(posedge adc_clk or posedge top_rst)
  begin
    if (top_rst)
      dat_o <= '0;
    else if (add_w > SAMPLE_MAX)
      dat_o <= SAMPLE_MAX;
    else if (add_w < SAMPLE_MIN)
      dat_o <= SAMPLE_MIN;
    else
      dat_o <= add_w[DWS-1:0];
  end

endmodule

//--- design/rp_channel.sv
// Pins are negative-slope offset binary, loopback feeds this channel's own DAC sample back
module rp_channel
  import rp_analog_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  logic [DWS-1:0]        adc_pin_i,      // Raw ADC pins
  input  logic                  digital_loop_i,
  input  logic signed [DWM-1:0] adc_mul_i,
  input  logic signed [DWS-1:0] adc_sum_i,
  input  logic signed [DWM-1:0] dac_mul_i,
  input  logic signed [DWS-1:0] dac_sum_i,
  input  logic signed [DWS-1:0] dac_level_i,    // Bus-written DAC source
  output logic signed [DWS-1:0] adc_dat_o,      // Calibrated ADC sample
  output logic signed [DWS-1:0] dac_cal_o       // Calibrated DAC sample
);

  logic signed [DWS-1:0] adc_raw_q;
  logic signed [DWS-1:0] adc_mux;

  //////////////////////////////////////////////////////////////////////
  // ADC input
  //////////////////////////////////////////////////////////////////////

  // Sign kept, magnitude bits flipped
  always_ff @(posedge adc_clk or posedge top_rst)
  begin
    if (top_rst)
      adc_raw_q <= '0;
    else
      adc_raw_q <= {adc_pin_i[DWS-1], ~adc_pin_i[DWS-2:0]};
  end

  assign adc_mux = digital_loop_i ? dac_cal_o : adc_raw_q;  // Loopback select

  rp_linear u_adc_lin (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (adc_mux),
    .mul_i   (adc_mul_i),
    .sum_i   (adc_sum_i),
    .dat_o   (adc_dat_o)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC calibration
  //////////////////////////////////////////////////////////////////////

  rp_linear u_dac_lin (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (dac_level_i),
    .mul_i   (dac_mul_i),
    .sum_i   (dac_sum_i),
    .dat_o   (dac_cal_o)
  );

endmodule

//--- design/rp_dac_out.sv
// Single-rate DAC bus shared by two channels, select starts low after reset
module rp_dac_out
  import rp_analog_pkg::*;
(
  input  logic                           adc_clk,
  input  logic                           top_rst,
  input  logic signed [CHN-1:0][DWS-1:0] dac_cal_i,  // Calibrated samples
  output logic [DWS-1:0]                 dac_dat_o,  // Interleaved DAC word
  output logic                           dac_sel_o   // High while channel A is out
);

  logic [CHN-1:0][DWS-1:0] dac_fmt;

  // Back to negative-slope offset binary
  always_comb
  begin
    for (int ch = 0; ch < CHN; ch++)
      dac_fmt[ch] = {dac_cal_i[ch][DWS-1], ~dac_cal_i[ch][DWS-2:0]};
  end

  // Load the channel that matches the next select value
  always_ff @(posedge adc_clk or posedge top_rst)
  begin
    if (top_rst)
    begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end
    else
    begin
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= dac_sel_o ? dac_fmt[1] : dac_fmt[0];  // Select goes high, A
    end
  end

endmodule

//--- design/rp_regs.sv
// Every write is a full word, strobes must be single-cycle pulses and never overlap
module rp_regs
  import rp_bus_pkg::*;
  import rp_analog_pkg::*;
(
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // System bus
  input  logic [SYS_AW-1:0]              sys_addr_i,
  input  logic [SYS_DW-1:0]              sys_wdata_i,
  input  logic                           sys_wen_i,
  input  logic                           sys_ren_i,
  output logic [SYS_DW-1:0]              sys_rdata_o,
  output logic                           sys_ack_o,
  output logic                           sys_err_o,
  // Configuration
  output logic                           digital_loop_o,
  output logic [7:0]                     led_o,
  output logic signed [CHN-1:0][DWM-1:0] adc_mul_o,
  output logic signed [CHN-1:0][DWS-1:0] adc_sum_o,
  output logic signed [CHN-1:0][DWM-1:0] dac_mul_o,
  output logic signed [CHN-1:0][DWS-1:0] dac_sum_o,
  output logic signed [CHN-1:0][DWS-1:0] dac_level_o
);

  rp_sys_addr_t addr;
  logic         hk_sel, cal_sel, lvl_sel, mapped;
  logic         hk_id_hit, hk_loop_hit, hk_led_hit;
  logic [CHN-1:0] adc_mul_hit, adc_sum_hit, dac_mul_hit, dac_sum_hit, lvl_hit;
  logic [SYS_DW-1:0] rd_val;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign addr.word = sys_addr_i;

  assign hk_sel  = (addr.fld.region == REG_HK);
  assign cal_sel = (addr.fld.region == REG_CALIB);
  assign lvl_sel = (addr.fld.region == REG_DACLVL);
  assign mapped  = hk_sel | cal_sel | lvl_sel;  // Anything else answers with error

  assign hk_id_hit   = hk_sel && (addr.fld.offset == HK_ID);
  assign hk_loop_hit = hk_sel && (addr.fld.offset == HK_LOOP);
  assign hk_led_hit  = hk_sel && (addr.fld.offset == HK_LED);

  // One word per channel in each group
  always_comb
  begin
    logic [19:0] ch_ofs;
    ch_ofs = '0;
    for (int ch = 0; ch < CHN; ch++)
    begin
      ch_ofs          = CH_STRIDE * 20'(ch);
      adc_mul_hit[ch] = cal_sel && (addr.fld.offset == CAL_ADC_MUL + ch_ofs);
      adc_sum_hit[ch] = cal_sel && (addr.fld.offset == CAL_ADC_SUM + ch_ofs);
      dac_mul_hit[ch] = cal_sel && (addr.fld.offset == CAL_DAC_MUL + ch_ofs);
      dac_sum_hit[ch] = cal_sel && (addr.fld.offset == CAL_DAC_SUM + ch_ofs);
      lvl_hit[ch]     = lvl_sel && (addr.fld.offset == LVL_A + ch_ofs);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst)
  begin
    if (top_rst)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      for (int ch = 0; ch < CHN; ch++)
      begin
        adc_mul_o[ch]   <= GAIN_UNITY;
        dac_mul_o[ch]   <= GAIN_UNITY;
        adc_sum_o[ch]   <= '0;
        dac_sum_o[ch]   <= '0;
        dac_level_o[ch] <= '0;
      end
    end
    else if (sys_wen_i)  // Visible in the ack cycle
    begin
      if (hk_loop_hit) digital_loop_o <= sys_wdata_i[0];
      if (hk_led_hit)  led_o          <= sys_wdata_i[7:0];
      for (int ch = 0; ch < CHN; ch++)
      begin
        if (adc_mul_hit[ch]) adc_mul_o[ch]   <= sys_wdata_i[DWM-1:0];
        if (adc_sum_hit[ch]) adc_sum_o[ch]   <= sys_wdata_i[DWS-1:0];
        if (dac_mul_hit[ch]) dac_mul_o[ch]   <= sys_wdata_i[DWM-1:0];
        if (dac_sum_hit[ch]) dac_sum_o[ch]   <= sys_wdata_i[DWS-1:0];
        if (lvl_hit[ch])     dac_level_o[ch] <= sys_wdata_i[DWS-1:0];
      end
    end
  end

  // Read mux, hits never overlap, zero-extended
  always_comb
  begin
    rd_val = '0;
    if (hk_id_hit)   rd_val = HK_ID_VALUE;
    if (hk_loop_hit) rd_val = SYS_DW'(digital_loop_o);
    if (hk_led_hit)  rd_val = SYS_DW'(led_o);
    for (int ch = 0; ch < CHN; ch++)
    begin
      if (adc_mul_hit[ch]) rd_val = SYS_DW'(adc_mul_o[ch]);
      if (adc_sum_hit[ch]) rd_val = SYS_DW'(adc_sum_o[ch]);
      if (dac_mul_hit[ch]) rd_val = SYS_DW'(dac_mul_o[ch]);
      if (dac_sum_hit[ch]) rd_val = SYS_DW'(dac_sum_o[ch]);
      if (lvl_hit[ch])     rd_val = SYS_DW'(dac_level_o[ch]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response, one cycle after the strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst)
  begin
    if (top_rst)
    begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end
    else
    begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= (sys_wen_i | sys_ren_i) & ~mapped;
      sys_rdata_o <= sys_ren_i ? rd_val : '0;  // Unmapped reads give zero
    end
  end

endmodule

//--- design/rp_top.sv
// Analog core only, one adc_clk domain, bus is 32-bit word access without byte select
module rp_top
  import rp_analog_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // ADC pins
  input  logic [DWS-1:0]        adc_dat_a_i,
  input  logic [DWS-1:0]        adc_dat_b_i,
  // System bus, 32-bit
  input  logic [32-1:0]         sys_addr_i,
  input  logic [32-1:0]         sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [32-1:0]         sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // Outputs
  output logic [7:0]            led_o,
  output logic signed [DWS-1:0] adc_dat_a_o,  // Calibrated ADC A
  output logic signed [DWS-1:0] adc_dat_b_o,  // Calibrated ADC B
  output logic [DWS-1:0]        dac_dat_o,
  output logic                  dac_sel_o
);

  logic                           digital_loop;
  logic signed [CHN-1:0][DWM-1:0] adc_mul, dac_mul;               // Gains
  logic signed [CHN-1:0][DWS-1:0] adc_sum, dac_sum, dac_level;    // Offsets and levels
  logic [CHN-1:0][DWS-1:0]        adc_pin;
  logic signed [CHN-1:0][DWS-1:0] adc_dat, dac_cal;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  rp_regs u_regs (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .sys_err_o      (sys_err_o),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .adc_mul_o      (adc_mul),
    .adc_sum_o      (adc_sum),
    .dac_mul_o      (dac_mul),
    .dac_sum_o      (dac_sum),
    .dac_level_o    (dac_level)
  );

  //////////////////////////////////////////////////////////////////////
  // Channels
  //////////////////////////////////////////////////////////////////////

  assign adc_pin[0]  = adc_dat_a_i;
  assign adc_pin[1]  = adc_dat_b_i;
  assign adc_dat_a_o = adc_dat[0];
  assign adc_dat_b_o = adc_dat[1];

  for (genvar ch = 0; ch < CHN; ch++)
  begin : g_chan
    rp_channel u_chan (
      .adc_clk        (adc_clk),
      .top_rst        (top_rst),
      .adc_pin_i      (adc_pin[ch]),
      .digital_loop_i (digital_loop),
      .adc_mul_i      (adc_mul[ch]),
      .adc_sum_i      (adc_sum[ch]),
      .dac_mul_i      (dac_mul[ch]),
      .dac_sum_i      (dac_sum[ch]),
      .dac_level_i    (dac_level[ch]),
      .adc_dat_o      (adc_dat[ch]),
      .dac_cal_o      (dac_cal[ch])
    );
  end

  // DAC interleave
  rp_dac_out u_dac_out (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_cal_i (dac_cal),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule

//--- sim/rp_top_checker.sv
// Bound into rp_top, checks bus ack timing, error qualification and DAC select toggling only
module rp_top_checker
(
  input logic adc_clk,
  input logic top_rst,
  input logic sys_wen_i,
  input logic sys_ren_i,
  input logic sys_ack_o,
  input logic sys_err_o,
  input logic dac_sel_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Ack exactly one cycle after each strobe
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (top_rst)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
  else
  begin
    fail_cnt++;
    $error("Strobe was not acknowledged on the next cycle");
  end

  // No ack without a strobe the cycle before
  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (top_rst)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
  else
  begin
    fail_cnt++;
    $error("Ack seen without a preceding strobe");
  end

  err_with_ack: assert property (@(posedge adc_clk) disable iff (top_rst)
    sys_err_o |-> sys_ack_o)  // Error qualifies an ack
  else
  begin
    fail_cnt++;
    $error("Bus error raised without ack");
  end

  // Select flips every cycle once out of reset
  sel_toggles: assert property (@(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> (dac_sel_o != $past(dac_sel_o)))
  else
  begin
    fail_cnt++;
    $error("DAC select did not toggle");
  end

endmodule

bind rp_top rp_top_checker u_checker (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .sys_wen_i (sys_wen_i),
  .sys_ren_i (sys_ren_i),
  .sys_ack_o (sys_ack_o),
  .sys_err_o (sys_err_o),
  .dac_sel_o (dac_sel_o)
);

//--- sim/tb_rp_top.sv
// Fixed seed stimulus that stops at the first mismatch and leaves ack timing to the bound checker
module tb_rp_top
  import rp_bus_pkg::*;
  import rp_analog_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RST_CYCLES     = 16;
  localparam int ADC_ROUNDS     = 4;
  localparam int ADC_CYCLES     = 1000;   // Pin samples per round
  localparam int TIMEOUT_CYCLES = 20000;  // Tests need about 6000
  localparam int NREGS          = 13;
  localparam int IDX_LOOP       = 1;      // Register list order
  localparam int IDX_LED        = 2;
  localparam int IDX_AMUL       = 3;
  localparam int IDX_ASUM       = 5;
  localparam int IDX_DMUL       = 7;
  localparam int IDX_DSUM       = 9;
  localparam int IDX_LVL        = 11;

  logic                  adc_clk, top_rst;
  logic [DWS-1:0]        adc_dat_a_i, adc_dat_b_i;
  logic [SYS_AW-1:0]     sys_addr_i;
  logic [SYS_DW-1:0]     sys_wdata_i, sys_rdata_o;
  logic                  sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o, dac_sel_o;
  logic [7:0]            led_o;
  logic signed [DWS-1:0] adc_dat_a_o, adc_dat_b_o;
  logic [DWS-1:0]        dac_dat_o;

  int          seed = 72115;
  int          cycle_cnt;
  logic [2:0]  reg_region [NREGS];
  logic [19:0] reg_offset [NREGS];
  logic [31:0] reg_mask   [NREGS];    // Zero marks read only
  logic [31:0] shadow     [NREGS];    // Expected register contents
  logic [DWS-1:0] pin_hist [CHN][ADC_CYCLES];

  rp_top u_dut (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 50 MHz
  end

  ////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////

  task abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_word(string name, logic [SYS_DW-1:0] exp, logic [SYS_DW-1:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_sample(string name, logic signed [DWS-1:0] exp,
                              logic signed [DWS-1:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_dac(string name, logic [DWS-1:0] exp, logic [DWS-1:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic int sample_of_pin(logic [DWS-1:0] pin);
    return int'(SAMPLE_MAX) - int'(pin);  // Full scale pin reads most negative
  endfunction

  function automatic logic [DWS-1:0] dac_word(int smp);
    return DWS'(int'(SAMPLE_MAX) - smp);  // Inverse of the pin rule
  endfunction

  // Floor of product over 2^14, plus offset, clamped
  function automatic int lin_model(int dat, int gain, int ofs);
    longint prod;
    longint res;
    prod = longint'(dat) * longint'(gain);
    res  = (prod >>> GAIN_SHIFT) + longint'(ofs);
    if (res > longint'(SAMPLE_MAX))
      res = longint'(SAMPLE_MAX);
    else if (res < longint'(SAMPLE_MIN))
      res = longint'(SAMPLE_MIN);
    return int'(res);
  endfunction

  function automatic int gain_val(logic [SYS_DW-1:0] word);
    return int'($signed(word[DWM-1:0]));
  endfunction

  function automatic int sample_val(logic [SYS_DW-1:0] word);
    return int'($signed(word[DWS-1:0]));
  endfunction

  function automatic int dac_model(int ch);
    return lin_model(sample_val(shadow[IDX_LVL + ch]), gain_val(shadow[IDX_DMUL + ch]),
                     sample_val(shadow[IDX_DSUM + ch]));
  endfunction

  function automatic logic signed [DWS-1:0] adc_model(int ch, int smp);
    return DWS'(lin_model(smp, gain_val(shadow[IDX_AMUL + ch]), sample_val(shadow[IDX_ASUM + ch])));
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////////////////////////////////

  function automatic logic [SYS_AW-1:0] make_addr(logic [2:0] region, logic [19:0] ofs);
    rp_sys_addr_t addr;
    addr.word       = '0;
    addr.fld.region = region;
    addr.fld.offset = ofs;
    return addr.word;
  endfunction

  task automatic bus_write(input logic [2:0] region, input logic [19:0] ofs,
                           input logic [SYS_DW-1:0] data, output logic err);
    @(posedge adc_clk);
    sys_addr_i  <= make_addr(region, ofs);
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;
    @(negedge adc_clk);
    while (!sys_ack_o)
      @(negedge adc_clk);  // Ack arrives on the cycle after the strobe
    err = sys_err_o;
  endtask

  task automatic bus_read(input logic [2:0] region, input logic [19:0] ofs,
                          output logic [SYS_DW-1:0] data, output logic err);
    @(posedge adc_clk);
    sys_addr_i <= make_addr(region, ofs);
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    @(negedge adc_clk);
    while (!sys_ack_o)
      @(negedge adc_clk);
    data = sys_rdata_o;
    err  = sys_err_o;
  endtask

  task automatic map_reg(int idx, logic [2:0] region, logic [19:0] ofs,
                         logic [31:0] mask, logic [31:0] init);
    reg_region[idx] = region;
    reg_offset[idx] = ofs;
    reg_mask[idx]   = mask;
    shadow[idx]     = init;  // Reset value
  endtask

  task automatic build_reg_map();
    map_reg(0, REG_HK, HK_ID, '0, HK_ID_VALUE);
    map_reg(IDX_LOOP, REG_HK, HK_LOOP, 32'h1, '0);
    map_reg(IDX_LED, REG_HK, HK_LED, 32'hff, '0);
    for (int ch = 0; ch < CHN; ch++)
    begin
      map_reg(IDX_AMUL + ch, REG_CALIB, CAL_ADC_MUL + 20'(4 * ch), 32'hffff, {16'h0, GAIN_UNITY});
      map_reg(IDX_ASUM + ch, REG_CALIB, CAL_ADC_SUM + 20'(4 * ch), 32'h3fff, '0);
      map_reg(IDX_DMUL + ch, REG_CALIB, CAL_DAC_MUL + 20'(4 * ch), 32'hffff, {16'h0, GAIN_UNITY});
      map_reg(IDX_DSUM + ch, REG_CALIB, CAL_DAC_SUM + 20'(4 * ch), 32'h3fff, '0);
      map_reg(IDX_LVL + ch, REG_DACLVL, LVL_A + 20'(4 * ch), 32'h3fff, '0);
    end
  endtask

  task automatic write_reg(int idx, logic [SYS_DW-1:0] data);
    logic err;
    bus_write(reg_region[idx], reg_offset[idx], data, err);
    check_flag($sformatf("write err %0d", idx), 1'b0, err);
    if (reg_mask[idx] != '0)  // Identifier keeps its value
      shadow[idx] = data & reg_mask[idx];
  endtask

  // Full random words, upper bits beyond each register must be dropped
  task automatic write_random(int lo, int hi);
    logic [SYS_DW-1:0] data;
    for (int i = lo; i <= hi; i++)
    begin
      data = $random(seed);
      write_reg(i, data);
    end
  endtask

  task automatic check_all_regs(string name);
    logic [SYS_DW-1:0] rdata;
    logic err;
    for (int i = 0; i < NREGS; i++)
    begin
      bus_read(reg_region[i], reg_offset[i], rdata, err);
      check_flag($sformatf("%s err %0d", name, i), 1'b0, err);
      check_word($sformatf("%s reg %0d", name, i), shadow[i], rdata);
    end
    check_word({name, " led_o"}, shadow[IDX_LED], {24'h0, led_o});
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////

  task automatic run_adc_round();
    write_reg(IDX_LOOP, 32'h0);
    write_random(IDX_AMUL, IDX_ASUM + CHN - 1);
    for (int i = 0; i < ADC_CYCLES; i++)
    begin
      @(posedge adc_clk);
      pin_hist[0][i] = DWS'($random(seed));
      pin_hist[1][i] = DWS'($random(seed));
      adc_dat_a_i <= pin_hist[0][i];
      adc_dat_b_i <= pin_hist[1][i];
      @(negedge adc_clk);
      if (i >= 3)  // Three edges from pin to output
      begin
        check_sample("adc_a", adc_model(0, sample_of_pin(pin_hist[0][i - 3])), adc_dat_a_o);
        check_sample("adc_b", adc_model(1, sample_of_pin(pin_hist[1][i - 3])), adc_dat_b_o);
      end
    end
  endtask

  task automatic run_dac_round();
    logic prev_sel;
    write_random(IDX_DMUL, NREGS - 1);  // DAC gains, offsets, levels
    repeat (8) @(negedge adc_clk);      // Settle
    prev_sel = dac_sel_o;
    for (int i = 0; i < 64; i++)
    begin
      @(negedge adc_clk);
      check_flag("dac_sel", ~prev_sel, dac_sel_o);
      check_dac(dac_sel_o ? "dac_a" : "dac_b", dac_word(dac_model(dac_sel_o ? 0 : 1)), dac_dat_o);
      prev_sel = dac_sel_o;
    end
  endtask

  task automatic run_loop_round();
    write_random(IDX_AMUL, NREGS - 1);
    write_reg(IDX_LOOP, 32'h1);
    repeat (8) @(negedge adc_clk);
    check_sample("loop_a", adc_model(0, dac_model(0)), adc_dat_a_o);
    check_sample("loop_b", adc_model(1, dac_model(1)), adc_dat_b_o);
    write_reg(IDX_LOOP, 32'h0);
  endtask

  task automatic check_unmapped();
    logic [SYS_DW-1:0] rdata;
    logic [19:0]       ofs;
    logic              err;
    for (int r = 0; r < 8; r++)
    begin
      if (3'(r) == REG_HK || 3'(r) == REG_DACLVL || 3'(r) == REG_CALIB)
        continue;
      ofs = 20'($random(seed) & 32'h1c);  // Offsets that exist elsewhere
      bus_write(3'(r), ofs, $random(seed), err);
      check_flag($sformatf("region %0d write err", r), 1'b1, err);
      bus_read(3'(r), ofs, rdata, err);
      check_flag($sformatf("region %0d read err", r), 1'b1, err);
      check_word($sformatf("region %0d rdata", r), '0, rdata);
    end
    check_all_regs("after unmapped");
  endtask

  // Watchdog and checker monitor
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES && u_dut.u_checker.fail_cnt == 0)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    if (u_dut.u_checker.fail_cnt != 0)
      $display("A bus or DAC select assertion failed");
    else
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
    abort_run();
  end

  initial
  begin
    top_rst     = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    build_reg_map();
    repeat (RST_CYCLES - 1) @(posedge adc_clk);
    @(negedge adc_clk);
    check_flag("reset ack", 1'b0, sys_ack_o);
    check_flag("reset err", 1'b0, sys_err_o);
    check_flag("reset sel", 1'b0, dac_sel_o);
    check_sample("reset adc_a", '0, adc_dat_a_o);
    check_sample("reset adc_b", '0, adc_dat_b_o);
    check_dac("reset dac", '0, dac_dat_o);
    @(posedge adc_clk);
    top_rst <= 1'b0;

    check_all_regs("reset");
    for (int r = 0; r < 4; r++)
    begin
      write_random(0, NREGS - 1);  // Identifier write must be ignored
      check_all_regs("readback");
    end
    for (int r = 0; r < ADC_ROUNDS; r++)
      run_adc_round();
    for (int r = 0; r < 4; r++)
      run_dac_round();
    for (int r = 0; r < 4; r++)
      run_loop_round();
    check_unmapped();

    @(negedge adc_clk);
    if (u_dut.u_checker.fail_cnt == 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("A bus or DAC select assertion failed");
      abort_run();
    end
  end

endmodule

//--- verilog.f
design/rp_bus_pkg.sv
design/rp_analog_pkg.sv
design/rp_linear.sv
design/rp_channel.sv
design/rp_dac_out.sv
design/rp_regs.sv
design/rp_top.sv
sim/rp_top_checker.sv
sim/tb_rp_top.sv

//--- run.sh
#!/bin/sh
# Builds with Verilator, runs the testbench and fails unless the pass line shows up
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_rp_top -f verilog.f -o tb_rp_top
out=$(./obj_dir/tb_rp_top +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
  exit 0
fi
exit 1
